//--- Bender.yml
package:
  name: rv_mem_wb

sources:
  - common/rv_pkg.sv
  - design/rv_mem_ctrl.sv
  - design/rv_dmem.sv
  - design/rv_load_ext.sv
  - design/rv_reg_mem_wb.sv
  - design/rv_writeback.sv
  - design/rv_mem_wb_top.sv
  - target: test
    files:
      - dv/rv_mem_wb_assert.sv
      - dv/rv_mem_wb_tb.sv

//--- common/rv_pkg.sv
package rv_pkg;

    // Datapath width and data memory geometry
    localparam int xlen       = 32;
    localparam int dmem_words = 256;
    localparam int dmem_idx_w = $clog2(dmem_words);

    // 1 registers the MEM/WB boundary, 0 passes it through
    localparam int mem_wb_reg = 1;

    // ADDI x0, x0, 0
    localparam logic [31:0] nop_instr = 32'h0000_0013;

    // Writeback result source
    typedef enum logic [2:0] {
        res_alu = 3'd0,
        res_mem = 3'd1,
        res_pc4 = 3'd2,
        res_jb  = 3'd3,
        res_csr = 3'd4
    } res_src_e;

    // Load/store funct3 encodings
    typedef enum logic [2:0] {
        f3_b  = 3'b000,
        f3_h  = 3'b001,
        f3_w  = 3'b010,
        f3_bu = 3'b100,
        f3_hu = 3'b101
    } funct3_e;

    typedef enum logic [1:0] {
        sz_byte = 2'd0,
        sz_half = 2'd1,
        sz_word = 2'd2
    } mem_size_e;

    // Executed instruction as it leaves EX/MEM
    typedef struct packed {
        logic            reg_write;
        logic            mem_write;
        res_src_e        res_src;
        funct3_e         funct3;
        logic [31:0]     instr;
        logic [4:0]      rd;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] store_data;
        logic [xlen-1:0] pc_plus4;
        logic [xlen-1:0] jb_target;
        logic [xlen-1:0] csr_rdata;
    } ex_mem_t;

    typedef struct packed {
        logic            reg_write;
        res_src_e        res_src;
        funct3_e         funct3;
        logic [31:0]     instr;
        logic [4:0]      rd;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] dmem_rdata_ext;
        logic [xlen-1:0] pc_plus4;
        logic [xlen-1:0] jb_target;
        logic [xlen-1:0] csr_rdata;
    } mem_wb_t;

    typedef struct packed {
        mem_size_e       size;
        logic            unsigned_load;
        logic [3:0]      byte_en;
        logic [xlen-1:0] wdata_shifted;
    } mem_ctrl_t;

    // Register file write port
    typedef struct packed {
        logic            we;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } wb_port_t;

endpackage

//--- design/rv_dmem.sv
`timescale 1ns/1ps

module rv_dmem (
    input  logic                     clk,
    input  logic                     mem_write,
    input  logic [rv_pkg::xlen-1:0]  addr,
    input  logic [3:0]               byte_en,
    input  logic [rv_pkg::xlen-1:0]  wdata,
    output logic [rv_pkg::xlen-1:0]  rdata
);

    logic [rv_pkg::xlen-1:0] mem [rv_pkg::dmem_words];

    // Word index from addr[9:2]
    logic [rv_pkg::dmem_idx_w-1:0] idx;

    assign idx = addr[rv_pkg::dmem_idx_w+1:2];

    // Only the enabled byte lanes are updated
    always_ff @(posedge clk) begin
        if (mem_write) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // Asynchronous read, so a store is seen by the next cycle's load
    assign rdata = mem[idx];

endmodule

//--- design/rv_load_ext.sv
`timescale 1ns/1ps

module rv_load_ext (
    input  logic [rv_pkg::xlen-1:0]  rdata,
    input  logic [1:0]               addr_lo,
    input  rv_pkg::mem_size_e        size,
    input  logic                     unsigned_load,
    output logic [rv_pkg::xlen-1:0]  rdata_ext
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    logic        byte_fill;
    logic        half_fill;

    assign byte_lane = rdata[{addr_lo, 3'b000} +: 8];
    assign half_lane = addr_lo[1] ? rdata[31:16] : rdata[15:0];

    // Sign bit of the lane, or zero for LBU/LHU
    assign byte_fill = byte_lane[7] & ~unsigned_load;
    assign half_fill = half_lane[15] & ~unsigned_load;

    always_comb begin
        unique case (size)
            rv_pkg::sz_byte: rdata_ext = {{(rv_pkg::xlen-8){byte_fill}}, byte_lane};
            rv_pkg::sz_half: rdata_ext = {{(rv_pkg::xlen-16){half_fill}}, half_lane};
            default:         rdata_ext = rdata;
        endcase
    end

endmodule

//--- design/rv_mem_ctrl.sv
`timescale 1ns/1ps

module rv_mem_ctrl (
    input  rv_pkg::funct3_e          funct3,
    input  logic [1:0]               addr_lo,
    input  logic [rv_pkg::xlen-1:0]  store_data,
    output rv_pkg::mem_ctrl_t        ctrl
);

    // Bit offset of the addressed lane
    logic [4:0] byte_shift;
    logic [4:0] half_shift;

    assign byte_shift = {addr_lo, 3'b000};
    assign half_shift = {addr_lo[1], 4'b0000};

    always_comb begin
        ctrl.unsigned_load = (funct3 == rv_pkg::f3_bu) || (funct3 == rv_pkg::f3_hu);

        unique case (funct3)
            rv_pkg::f3_b,
            rv_pkg::f3_bu: begin
                ctrl.size          = rv_pkg::sz_byte;
                ctrl.byte_en       = 4'b0001 << addr_lo;
                ctrl.wdata_shifted = {{(rv_pkg::xlen-8){1'b0}}, store_data[7:0]}
                                     << byte_shift;
            end
            rv_pkg::f3_h,
            rv_pkg::f3_hu: begin
                // Halfword lane picked by addr[1], addr[0] ignored
                ctrl.size          = rv_pkg::sz_half;
                ctrl.byte_en       = 4'b0011 << {addr_lo[1], 1'b0};
                ctrl.wdata_shifted = {{(rv_pkg::xlen-16){1'b0}}, store_data[15:0]}
                                     << half_shift;
            end
            default: begin
                // Word access, low address bits ignored
                ctrl.size          = rv_pkg::sz_word;
                ctrl.byte_en       = 4'b1111;
                ctrl.wdata_shifted = store_data;
            end
        endcase
    end

endmodule

//--- design/rv_mem_wb_top.sv
`timescale 1ns/1ps

module rv_mem_wb_top #(
    parameter int mem_wb_reg = rv_pkg::mem_wb_reg
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rv_pkg::ex_mem_t          ex_mem,
    input  logic [4:0]               raddr_a,
    input  logic [4:0]               raddr_b,
    output rv_pkg::wb_port_t         wb,
    output logic [31:0]              instr_wb,
    output logic [rv_pkg::xlen-1:0]  rdata_a,
    output logic [rv_pkg::xlen-1:0]  rdata_b
);

    rv_pkg::mem_ctrl_t        mem_ctrl;
    logic [rv_pkg::xlen-1:0]  dmem_rdata;
    logic [rv_pkg::xlen-1:0]  dmem_rdata_ext;
    rv_pkg::mem_wb_t          mem_wb_d;
    rv_pkg::mem_wb_t          mem_wb_q;

    rv_mem_ctrl u_mem_ctrl (
        .funct3     (ex_mem.funct3),
        .addr_lo    (ex_mem.alu_result[1:0]),
        .store_data (ex_mem.store_data),
        .ctrl       (mem_ctrl)
    );

    rv_dmem u_dmem (
        .clk       (clk),
        .mem_write (ex_mem.mem_write),
        .addr      (ex_mem.alu_result),
        .byte_en   (mem_ctrl.byte_en),
        .wdata     (mem_ctrl.wdata_shifted),
        .rdata     (dmem_rdata)
    );

    rv_load_ext u_load_ext (
        .rdata         (dmem_rdata),
        .addr_lo       (ex_mem.alu_result[1:0]),
        .size          (mem_ctrl.size),
        .unsigned_load (mem_ctrl.unsigned_load),
        .rdata_ext     (dmem_rdata_ext)
    );

    // MEM stage fields plus the extended load data
    always_comb begin
        mem_wb_d.reg_write      = ex_mem.reg_write;
        mem_wb_d.res_src        = ex_mem.res_src;
        mem_wb_d.funct3         = ex_mem.funct3;
        mem_wb_d.instr          = ex_mem.instr;
        mem_wb_d.rd             = ex_mem.rd;
        mem_wb_d.alu_result     = ex_mem.alu_result;
        mem_wb_d.dmem_rdata_ext = dmem_rdata_ext;
        mem_wb_d.pc_plus4       = ex_mem.pc_plus4;
        mem_wb_d.jb_target      = ex_mem.jb_target;
        mem_wb_d.csr_rdata      = ex_mem.csr_rdata;
    end

    rv_reg_mem_wb #(
        .mem_wb_reg (mem_wb_reg)
    ) u_reg_mem_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

    rv_writeback u_writeback (
        .clk     (clk),
        .rst_n   (rst_n),
        .q       (mem_wb_q),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .wb      (wb),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    assign instr_wb = mem_wb_q.instr;

endmodule

//--- design/rv_reg_mem_wb.sv
`timescale 1ns/1ps

module rv_reg_mem_wb #(
    parameter int mem_wb_reg = rv_pkg::mem_wb_reg
) (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::mem_wb_t  d,
    output rv_pkg::mem_wb_t  q
);

    if (mem_wb_reg != 0) begin : g_registered

        always_ff @(posedge clk) begin
            // Datapath fields carry no reset
            q.res_src        <= d.res_src;
            q.rd             <= d.rd;
            q.alu_result     <= d.alu_result;
            q.dmem_rdata_ext <= d.dmem_rdata_ext;
            q.pc_plus4       <= d.pc_plus4;
            q.jb_target      <= d.jb_target;
            q.csr_rdata      <= d.csr_rdata;

            // Control fields come up as a bubble
            if (!rst_n) begin
                q.reg_write <= 1'b0;
                q.funct3    <= rv_pkg::f3_b;
                q.instr     <= rv_pkg::nop_instr;
            end else begin
                q.reg_write <= d.reg_write;
                q.funct3    <= d.funct3;
                q.instr     <= d.instr;
            end
        end

    end else begin : g_passthrough

        // Stage collapsed, MEM feeds WB in the same cycle
        assign q = d;

    end

endmodule

//--- design/rv_writeback.sv
`timescale 1ns/1ps

module rv_writeback (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rv_pkg::mem_wb_t          q,
    input  logic [4:0]               raddr_a,
    input  logic [4:0]               raddr_b,
    output rv_pkg::wb_port_t         wb,
    output logic [rv_pkg::xlen-1:0]  rdata_a,
    output logic [rv_pkg::xlen-1:0]  rdata_b
);

    logic [rv_pkg::xlen-1:0] result;

    // x1..x31 only, x0 has no storage
    logic [rv_pkg::xlen-1:0] regs [1:31];

    always_comb begin
        unique case (q.res_src)
            rv_pkg::res_mem: result = q.dmem_rdata_ext;
            rv_pkg::res_pc4: result = q.pc_plus4;
            rv_pkg::res_jb:  result = q.jb_target;
            rv_pkg::res_csr: result = q.csr_rdata;
            default:         result = q.alu_result;
        endcase
    end

    always_comb begin
        wb.we   = q.reg_write && (q.rd != 5'd0);
        wb.rd   = q.rd;
        wb.data = result;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // No write-through, a write is readable the cycle after
    assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

endmodule

//--- dv/rv_mem_wb_assert.sv
`timescale 1ns/1ps

module rv_mem_wb_assert (
    input logic             clk,
    input logic             rst_n,
    input rv_pkg::ex_mem_t  ex_mem,
    input rv_pkg::wb_port_t wb,
    input logic [31:0]      instr_wb
);

    int fail_count = 0;

    // Register write only for a nonzero rd issued one cycle earlier
    a_we_issued: assert property (@(posedge clk) disable iff (!rst_n)
        wb.we |-> wb.rd != 5'd0 && $past(ex_mem.reg_write) && wb.rd == $past(ex_mem.rd))
        else begin
            $error("wb.we set without a matching write issued the cycle before");
            fail_count++;
        end

    // First cycle out of reset still holds a bubble
    a_we_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !wb.we)
        else begin
            $error("wb.we high in the first cycle after reset");
            fail_count++;
        end

    a_nop_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> instr_wb == rv_pkg::nop_instr)
        else begin
            $error("instr_wb is not a NOP in the first cycle after reset");
            fail_count++;
        end

endmodule

//--- dv/rv_mem_wb_tb.sv
`timescale 1ns/1ps

module rv_mem_wb_tb;

    logic             clk;
    logic             rst_n;
    rv_pkg::ex_mem_t  ex_mem;
    logic [4:0]       raddr_a;
    logic [4:0]       raddr_b;
    rv_pkg::wb_port_t wb;
    logic [31:0]      instr_wb;
    logic [31:0]      rdata_a;
    logic [31:0]      rdata_b;

    integer           seed;
    int               errors;
    int               test_errors;
    int               tests_failed;
    logic [31:0]      a;
    logic [4:0]       rd;
    logic [31:0]      exp_instr;
    logic [7:0]       mem_model [1024];
    logic [31:0]      reg_model [32];
    rv_pkg::wb_port_t exp_q [$];
    rv_pkg::funct3_e  loads [4] = '{rv_pkg::f3_b, rv_pkg::f3_h, rv_pkg::f3_bu, rv_pkg::f3_hu};
    rv_pkg::res_src_e srcs [4] = '{rv_pkg::res_alu, rv_pkg::res_pc4, rv_pkg::res_jb,
                                   rv_pkg::res_csr};

    rv_mem_wb_top #(.mem_wb_reg(1)) uut (.*);

    bind rv_mem_wb_top rv_mem_wb_assert u_assert (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #200000;
        $display("Timeout: the stimulus did not complete in time");
        $display("Test failed");
        $finish;
    end

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            $display("Error at %0t ns: %s", $time, msg);
            test_errors++;
        end
    endtask

    // Bytes touched by a load or store
    function automatic int nbytes(input rv_pkg::funct3_e f3);
        case (f3)
            rv_pkg::f3_w:                return 4;
            rv_pkg::f3_h, rv_pkg::f3_hu: return 2;
            default:                     return 1;
        endcase
    endfunction

    function automatic rv_pkg::ex_mem_t mk(input rv_pkg::funct3_e f3, input rv_pkg::res_src_e rs,
                                           input logic rw, input logic mw, input logic [4:0] r,
                                           input logic [31:0] addr, input logic [31:0] sd);
        rv_pkg::ex_mem_t e;
        e.reg_write  = rw;
        e.mem_write  = mw;
        e.res_src    = rs;
        e.funct3     = f3;
        e.instr      = $random(seed);
        e.rd         = r;
        e.alu_result = addr;
        e.store_data = sd;
        e.pc_plus4   = $random(seed);
        e.jb_target  = $random(seed);
        e.csr_rdata  = $random(seed);
        return e;
    endfunction

    function automatic rv_pkg::ex_mem_t bubble();
        return mk(rv_pkg::f3_w, rv_pkg::res_alu, 1'b0, 1'b0, 5'd0, 32'd0, 32'd0);
    endfunction

    // Expected rd value with loads taken from the byte model
    function automatic logic [31:0] result_of(input rv_pkg::ex_mem_t e);
        logic [31:0] w;
        logic [9:0]  base;
        int          n;
        n    = nbytes(e.funct3);
        base = e.alu_result[9:0] & ~10'(n - 1);
        w    = '0;
        for (int i = 0; i < n; i++)
            w[8*i +: 8] = mem_model[base + i];
        if (e.funct3 == rv_pkg::f3_b)
            w = {{24{w[7]}}, w[7:0]};
        if (e.funct3 == rv_pkg::f3_h)
            w = {{16{w[15]}}, w[15:0]};
        case (e.res_src)
            rv_pkg::res_mem: return w;
            rv_pkg::res_pc4: return e.pc_plus4;
            rv_pkg::res_jb:  return e.jb_target;
            rv_pkg::res_csr: return e.csr_rdata;
            default:         return e.alu_result;
        endcase
    endfunction

    // Checks the previous issue on wb and then presents the next one
    task automatic step(input rv_pkg::ex_mem_t e, input logic [4:0] rb);
        rv_pkg::wb_port_t x;
        logic [9:0]       base;
        @(negedge clk);
        check(rdata_a === reg_model[raddr_a], "read port a mismatch");
        check(rdata_b === reg_model[raddr_b], "read port b mismatch");
        check(instr_wb === exp_instr, "instr_wb mismatch");
        raddr_a = 5'd0;
        if (exp_q.size() > 0) begin
            x = exp_q.pop_front();
            check(wb.we === x.we, "wb.we mismatch");
            if (x.we) begin
                check(wb.rd === x.rd && wb.data === x.data, "wb rd or data mismatch");
                reg_model[x.rd] = x.data;
                raddr_a = x.rd;
            end
        end
        x.we   = e.reg_write && (e.rd != 5'd0);
        x.rd   = e.rd;
        x.data = result_of(e);
        exp_q.push_back(x);
        if (e.mem_write) begin
            base = e.alu_result[9:0] & ~10'(nbytes(e.funct3) - 1);
            for (int i = 0; i < nbytes(e.funct3); i++)
                mem_model[base + i] = e.store_data[8*i +: 8];
        end
        ex_mem    = e;
        raddr_b   = rb;
        exp_instr = e.instr;
    endtask

    task automatic finish_test(input string name);
        repeat (2) step(bubble(), 5'd0);
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errors);
            tests_failed++;
        end
        errors      += test_errors;
        test_errors  = 0;
    endtask

    initial begin
        seed         = 32'h49d2;
        errors       = 0;
        test_errors  = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        raddr_a      = 5'd0;
        raddr_b      = 5'd0;
        // A register write held at the input while the pipeline register is in reset
        ex_mem       = mk(rv_pkg::f3_w, rv_pkg::res_alu, 1'b1, 1'b0, 5'd1, 32'd0, 32'd0);
        for (int i = 0; i < 32; i++)
            reg_model[i] = '0;
        repeat (8) @(negedge clk);
        check(wb.we === 1'b0 && instr_wb === rv_pkg::nop_instr, "reset values wrong");
        rst_n     = 1'b1;
        ex_mem    = bubble();
        exp_instr = ex_mem.instr;
        for (int i = 0; i < 32; i++)
            step(bubble(), 5'(i));
        finish_test("reset state");

        for (int k = 0; k < 4; k++) begin
            a = $random(seed) & 32'h3fc;
            step(mk(rv_pkg::f3_w, rv_pkg::res_alu, 1'b0, 1'b1, 5'd0, a, $random(seed)), 5'd0);
            step(mk(rv_pkg::f3_w, rv_pkg::res_mem, 1'b1, 1'b0, 5'(k + 1), a, 0), 5'(k + 1));
        end
        finish_test("word store then load");

        // Word fill followed by a halfword in the other lane and a byte at the offset
        for (int off = 0; off < 4; off++) begin
            a = ($random(seed) & 32'h3fc) | off;
            step(mk(rv_pkg::f3_w, rv_pkg::res_alu, 1'b0, 1'b1, 5'd0, a, $random(seed)), 5'd0);
            step(mk(rv_pkg::f3_h, rv_pkg::res_alu, 1'b0, 1'b1, 5'd0, a ^ 2, $random(seed)), 5'd0);
            step(mk(rv_pkg::f3_b, rv_pkg::res_alu, 1'b0, 1'b1, 5'd0, a, $random(seed)), 5'd0);
            step(mk(rv_pkg::f3_w, rv_pkg::res_mem, 1'b1, 1'b0, 5'd7, a, 0), 5'd0);
        end
        finish_test("sub-word stores");

        for (int off = 0; off < 4; off++) begin
            a = ($random(seed) & 32'h3fc) | off;
            step(mk(rv_pkg::f3_w, rv_pkg::res_alu, 1'b0, 1'b1, 5'd0, a, $random(seed)), 5'd0);
            for (int j = 0; j < 4; j++)
                step(mk(loads[j], rv_pkg::res_mem, 1'b1, 1'b0, 5'($random(seed)), a, 0), 5'd0);
        end
        finish_test("load extension");

        for (int k = 0; k < 40; k++) begin
            rd = $random(seed);
            step(mk(rv_pkg::f3_w, srcs[$unsigned($random(seed)) % 4], 1'b1, 1'b0, rd,
                    $random(seed), 0), 5'($random(seed)));
        end
        finish_test("result selection");

        for (int k = 0; k < 20; k++) begin
            rd = $random(seed);
            step(mk(rv_pkg::f3_w, rv_pkg::res_alu, 1'b1, 1'b0, 5'd0, $random(seed), 0), rd);
            step(mk(rv_pkg::f3_w, rv_pkg::res_csr, 1'b0, 1'b0, rd, $random(seed), 0), rd);
        end
        finish_test("suppressed writes");

        errors += uut.u_assert.fail_count;
        $display("6 tests, %0d failed, %0d errors", tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rv_mem_wb_top.f
common/rv_pkg.sv
design/rv_mem_ctrl.sv
design/rv_dmem.sv
design/rv_load_ext.sv
design/rv_reg_mem_wb.sv
design/rv_writeback.sv
design/rv_mem_wb_top.sv
dv/rv_mem_wb_assert.sv
dv/rv_mem_wb_tb.sv
